//--- Bender.yml
package:
  name: mem_subsys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_pkg.sv
      - hdl/data_mem_if.sv
      - hdl/mem_stage.sv
      - hdl/axil_host_port.sv
      - hdl/mem_arbiter.sv
      - hdl/data_ram.sv
      - hdl/mem_subsys_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_mem_subsys.sv

//--- files.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/data_mem_if.sv
hdl/mem_stage.sv
hdl/axil_host_port.sv
hdl/mem_arbiter.sv
hdl/data_ram.sv
hdl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

//--- hdl/axil_host_port.sv
`default_nettype none

`include "mem_defines.svh"

module axil_host_port (
  input  wire logic           clk,
  input  wire logic           rst_n,
  // write address and data
  input  wire logic           awvalid,
  output logic                awready,
  input  wire mem_pkg::word_t awaddr,
  input  wire logic           wvalid,
  output logic                wready,
  input  wire mem_pkg::word_t wdata,
  input  wire mem_pkg::be_t   wstrb,
  // write response
  output logic                bvalid,
  input  wire logic           bready,
  output logic [1:0]          bresp,
  // read address
  input  wire logic           arvalid,
  output logic                arready,
  input  wire mem_pkg::word_t araddr,
  // read data
  output logic                rvalid,
  input  wire logic           rready,
  output mem_pkg::word_t      rdata,
  output logic [1:0]          rresp,
  data_mem_if.requester       mem
);
  import mem_pkg::*;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [2:0] {
    h_idle, h_wr_wait, h_rd_wait, h_rd_data, h_resp
  } host_state_e;

  host_state_e         state_q;
  host_state_e         state_d;
  logic                is_wr_q;
  logic                take_rd;
  logic                take_wr;
  logic [`DMEM_AW-1:0] addr_q;
  word_t               wdata_q;
  be_t                 wstrb_q;
  word_t               rdata_q;

  ////////////////////////////////////////
  // address phase
  ////////////////////////////////////////

  // one transaction at a time, reads first
  assign take_rd = (state_q == h_idle) && arvalid;
  assign take_wr = (state_q == h_idle) && awvalid && wvalid && !arvalid;

  assign arready = take_rd;
  // aw and w accepted in the same cycle
  assign awready = take_wr;
  assign wready  = take_wr;

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      h_idle: begin
        if (take_rd) begin
          state_d = h_rd_wait;
        end else if (take_wr) begin
          state_d = h_wr_wait;
        end
      end
      // hold the request until granted
      h_wr_wait: if (mem.gnt) state_d = h_resp;
      h_rd_wait: if (mem.gnt) state_d = h_rd_data;
      // ram data valid now, done if the master is ready
      h_rd_data: state_d = rready ? h_idle : h_resp;
      h_resp:    if (is_wr_q ? bready : rready) state_d = h_idle;
      default:   state_d = h_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= h_idle;
      is_wr_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take_rd || take_wr) begin
        is_wr_q <= take_wr;
      end
    end
  end

  // captured request and read data
  always_ff @(posedge clk) begin
    if (take_rd) begin
      addr_q <= araddr[`DMEM_AW+1:2];
    end else if (take_wr) begin
      addr_q  <= awaddr[`DMEM_AW+1:2];
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (state_q == h_rd_data) begin
      rdata_q <= mem.rdata;
    end
  end

  // memory request
  assign mem.req   = (state_q == h_wr_wait) || (state_q == h_rd_wait);
  assign mem.we    = (state_q == h_wr_wait);
  assign mem.be    = mem.we ? wstrb_q : be_t'(4'b1111);
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  // responses, always okay
  assign bvalid = (state_q == h_resp) && is_wr_q;
  assign bresp  = resp_okay;
  assign rvalid = (state_q == h_rd_data) || ((state_q == h_resp) && !is_wr_q);
  // straight from the ram on the first cycle, then the held copy
  assign rdata  = (state_q == h_rd_data) ? mem.rdata : rdata_q;
  assign rresp  = resp_okay;

endmodule

`default_nettype wire

//--- hdl/data_mem_if.sv
`default_nettype none

`include "mem_defines.svh"

interface data_mem_if;
  import mem_pkg::*;

  // request side
  logic                req;
  logic                we;
  be_t                 be;
  logic [`DMEM_AW-1:0] addr;
  word_t               wdata;
  // arbiter answer, same cycle as req
  logic                gnt;
  // read data, one cycle after the taken request
  word_t               rdata;

  // pipeline stage or host port
  modport requester (output req, we, be, addr, wdata,
                     input  gnt, rdata);

  // arbiter side facing one requester
  modport arbiter (input  req, we, be, addr, wdata,
                   output gnt, rdata);

  // arbiter side facing the ram
  modport to_mem (output req, we, be, addr, wdata, gnt,
                  input  rdata);

  // the ram itself
  modport memory (input  req, we, be, addr, wdata, gnt,
                  output rdata);

endinterface

`default_nettype wire

//--- hdl/data_ram.sv
`default_nettype none

`include "mem_defines.svh"

module data_ram (
  input wire logic   clk,
  data_mem_if.memory mem
);
  import mem_pkg::*;

  // storage, no reset
  word_t mem_array [`DMEM_WORDS];

  ////////////////////////////////////////
  // single port access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (mem.req && mem.gnt) begin
      if (mem.we) begin
        // per byte lane write
        for (int i = 0; i < 4; i++) begin
          if (mem.be[i]) begin
            mem_array[mem.addr][i*8 +: 8] <= mem.wdata[i*8 +: 8];
          end
        end
      end else begin
        // read data out one cycle later
        mem.rdata <= mem_array[mem.addr];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
  input wire logic    clk,
  input wire logic    rst_n,
  // pipeline memory stage, highest priority
  data_mem_if.arbiter core,
  // debug host port
  data_mem_if.arbiter host,
  // shared ram
  data_mem_if.to_mem  ram
);
  import mem_pkg::*;

  logic  host_rd_q;
  word_t core_rdata_q;

  ////////////////////////////////////////
  // grant and request mux
  ////////////////////////////////////////

  // core never waits
  assign core.gnt = core.req;
  // host only in cycles the core leaves free
  assign host.gnt = host.req && !core.req;

  assign ram.req   = core.req || host.req;
  assign ram.gnt   = core.gnt || host.gnt;
  assign ram.we    = core.req ? core.we    : host.we;
  assign ram.be    = core.req ? core.be    : host.be;
  assign ram.addr  = core.req ? core.addr  : host.addr;
  assign ram.wdata = core.req ? core.wdata : host.wdata;

  ////////////////////////////////////////
  // read data return
  ////////////////////////////////////////

  // ram output holds a host word until the core reads again
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_rd_q <= 1'b0;
    end else if (host.gnt && !host.we) begin
      host_rd_q <= 1'b1;
    end else if (core.gnt && !core.we) begin
      host_rd_q <= 1'b0;
    end
  end

  // last word that did not belong to the host
  always_ff @(posedge clk) begin
    if (!host_rd_q) begin
      core_rdata_q <= ram.rdata;
    end
  end

  // host sees the ram output directly
  assign host.rdata = ram.rdata;
  // core keeps its own word across host reads
  // so a frozen mem/wb result stays put
  assign core.rdata = host_rd_q ? core_rdata_q : ram.rdata;

endmodule

`default_nettype wire

//--- hdl/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

////////////////////////////////////////
// data memory geometry
////////////////////////////////////////

// word address width of the data ram
// byte address bits [1:0] select the lane
`define DMEM_AW 10

// number of 32-bit words, 2**DMEM_AW
`define DMEM_WORDS 1024

`endif

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////
  // basic data types
  ////////////////////////////////////////

  // one data word
  typedef logic [31:0] word_t;

  // register number
  typedef logic [4:0] reg_idx_t;

  // one enable per byte lane
  typedef logic [3:0] be_t;

  ////////////////////////////////////////
  // pipeline control encodings
  ////////////////////////////////////////

  // load type, one-hot
  // ld_none gives a zero load result
  typedef enum logic [4:0] {
    ld_none = 5'b00000,
    ld_lb   = 5'b00001,
    ld_lh   = 5'b00010,
    ld_lw   = 5'b00100,
    ld_lbu  = 5'b01000,
    ld_lhu  = 5'b10000
  } load_ctrl_e;

  // store type, one-hot
  // st_none keeps all byte enables set
  typedef enum logic [2:0] {
    st_none = 3'b000,
    st_sb   = 3'b001,
    st_sh   = 3'b010,
    st_sw   = 3'b100
  } store_ctrl_e;

  // memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } mem_word_u;

endpackage

`default_nettype wire

//--- hdl/mem_stage.sv
`default_nettype none

`include "mem_defines.svh"

module mem_stage (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 dbg,
  // ex/mem pipeline fields
  input  wire mem_pkg::word_t       ex_mem_alures,
  input  wire mem_pkg::word_t       ex_mem_dout_rs2,
  input  wire mem_pkg::reg_idx_t    ex_mem_rs2,
  input  wire mem_pkg::reg_idx_t    ex_mem_rd,
  input  wire logic                 ex_mem_regwrite,
  input  wire logic                 ex_mem_memread,
  input  wire logic                 ex_mem_memwrite,
  input  wire mem_pkg::load_ctrl_e  ex_mem_loadctrl,
  input  wire mem_pkg::store_ctrl_e ex_mem_storectrl,
  // result of the instruction now in writeback
  input  wire mem_pkg::word_t       wb_res,
  // mem/wb pipeline fields
  output mem_pkg::word_t            mem_wb_alures,
  output mem_pkg::reg_idx_t         mem_wb_rd,
  output logic                      mem_wb_regwrite,
  output logic                      mem_wb_memread,
  output mem_pkg::word_t            mem_wb_memres,
  data_mem_if.requester             mem
);
  import mem_pkg::*;

  logic [1:0] off;
  be_t        be;
  logic       fwd;
  word_t      store_src;
  logic [1:0] off_q;
  logic [1:0] load_shift;
  load_ctrl_e ld_q;
  mem_word_u  load_w;

  // rotate a word left by n byte lanes
  function automatic word_t rotl_bytes(input word_t w, input logic [1:0] n);
    word_t r;
    case (n)
      2'd0:    r = w;
      2'd1:    r = {w[23:0], w[31:24]};
      2'd2:    r = {w[15:0], w[31:16]};
      default: r = {w[7:0], w[31:8]};
    endcase
    return r;
  endfunction

  ////////////////////////////////////////
  // store path
  ////////////////////////////////////////

  // byte offset inside the word
  assign off = ex_mem_alures[1:0];

  always_comb begin
    case (ex_mem_storectrl)
      st_sb: be = be_t'(4'b0001 << off);
      st_sh: begin
        // halfword at offset 3 wraps into lane 0
        case (off)
          2'd0:    be = 4'b0011;
          2'd1:    be = 4'b0110;
          2'd2:    be = 4'b1100;
          default: be = 4'b1001;
        endcase
      end
      // sw and no store
      default: be = 4'b1111;
    endcase
  end

  // previous instruction writes the register this store reads
  assign fwd = mem_wb_regwrite && (mem_wb_rd != 5'd0) && (mem_wb_rd == ex_mem_rs2);
  assign store_src = fwd ? wb_res : ex_mem_dout_rs2;

  // no request while halted for the host
  assign mem.req   = (ex_mem_memread || ex_mem_memwrite) && !dbg;
  assign mem.we    = ex_mem_memwrite;
  assign mem.be    = be;
  assign mem.addr  = ex_mem_alures[`DMEM_AW+1:2];
  // data moved into the addressed lanes
  assign mem.wdata = rotl_bytes(store_src, off);

  ////////////////////////////////////////
  // mem/wb register
  ////////////////////////////////////////

  // control fields, frozen while dbg is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_wb_regwrite <= 1'b0;
      mem_wb_memread  <= 1'b0;
      ld_q            <= ld_none;
    end else if (!dbg) begin
      mem_wb_regwrite <= ex_mem_regwrite;
      mem_wb_memread  <= ex_mem_memread;
      // load type only kept when a read was actually taken
      ld_q            <= (mem.gnt && !mem.we) ? ex_mem_loadctrl : ld_none;
    end
  end

  // data fields
  always_ff @(posedge clk) begin
    if (!dbg) begin
      mem_wb_alures <= ex_mem_alures;
      mem_wb_rd     <= ex_mem_rd;
      off_q         <= off;
    end
  end

  ////////////////////////////////////////
  // load path
  ////////////////////////////////////////

  // right rotate by off_q is a left rotate by 4 - off_q
  assign load_shift = 2'd0 - off_q;
  // addressed byte or half lands in the low lanes
  assign load_w = rotl_bytes(mem.rdata, load_shift);

  always_comb begin
    case (ld_q)
      ld_lb:   mem_wb_memres = {{24{load_w.b[0][7]}}, load_w.b[0]};
      ld_lh:   mem_wb_memres = {{16{load_w.h[0][15]}}, load_w.h[0]};
      ld_lw:   mem_wb_memres = word_t'(load_w);
      ld_lbu:  mem_wb_memres = {24'h000000, load_w.b[0]};
      ld_lhu:  mem_wb_memres = {16'h0000, load_w.h[0]};
      default: mem_wb_memres = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top (
  input  wire logic                 bus,
  input  wire logic                 rst_n,
  input  wire logic                 dbg,
  // ex/mem fields
  input  wire mem_pkg::word_t       ex_mem_alures,
  input  wire mem_pkg::word_t       ex_mem_dout_rs2,
  input  wire mem_pkg::reg_idx_t    ex_mem_rs2,
  input  wire mem_pkg::reg_idx_t    ex_mem_rd,
  input  wire logic                 ex_mem_regwrite,
  input  wire logic                 ex_mem_memread,
  input  wire logic                 ex_mem_memwrite,
  input  wire mem_pkg::load_ctrl_e  ex_mem_loadctrl,
  input  wire mem_pkg::store_ctrl_e ex_mem_storectrl,
  input  wire mem_pkg::word_t       wb_res,
  // mem/wb fields
  output mem_pkg::word_t            mem_wb_alures,
  output mem_pkg::reg_idx_t         mem_wb_rd,
  output logic                      mem_wb_regwrite,
  output logic                      mem_wb_memread,
  output mem_pkg::word_t            mem_wb_memres,
  // axi4-lite debug host
  input  wire logic                 s_axil_awvalid,
  output logic                      s_axil_awready,
  input  wire mem_pkg::word_t       s_axil_awaddr,
  input  wire logic                 s_axil_wvalid,
  output logic                      s_axil_wready,
  input  wire mem_pkg::word_t       s_axil_wdata,
  input  wire mem_pkg::be_t         s_axil_wstrb,
  output logic                      s_axil_bvalid,
  input  wire logic                 s_axil_bready,
  output logic [1:0]                s_axil_bresp,
  input  wire logic                 s_axil_arvalid,
  output logic                      s_axil_arready,
  input  wire mem_pkg::word_t       s_axil_araddr,
  output logic                      s_axil_rvalid,
  input  wire logic                 s_axil_rready,
  output mem_pkg::word_t            s_axil_rdata,
  output logic [1:0]                s_axil_rresp
);

  // stage, host and ram links
  data_mem_if core_if ();
  data_mem_if host_if ();
  data_mem_if ram_if ();

  ////////////////////////////////////////
  // requesters
  ////////////////////////////////////////

  mem_stage i_mem_stage (
    .clk              (bus),
    .rst_n            (rst_n),
    .dbg              (dbg),
    .ex_mem_alures    (ex_mem_alures),
    .ex_mem_dout_rs2  (ex_mem_dout_rs2),
    .ex_mem_rs2       (ex_mem_rs2),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_regwrite  (ex_mem_regwrite),
    .ex_mem_memread   (ex_mem_memread),
    .ex_mem_memwrite  (ex_mem_memwrite),
    .ex_mem_loadctrl  (ex_mem_loadctrl),
    .ex_mem_storectrl (ex_mem_storectrl),
    .wb_res           (wb_res),
    .mem_wb_alures    (mem_wb_alures),
    .mem_wb_rd        (mem_wb_rd),
    .mem_wb_regwrite  (mem_wb_regwrite),
    .mem_wb_memread   (mem_wb_memread),
    .mem_wb_memres    (mem_wb_memres),
    .mem              (core_if.requester)
  );

  axil_host_port i_host_port (
    .clk     (bus),
    .rst_n   (rst_n),
    .awvalid (s_axil_awvalid),
    .awready (s_axil_awready),
    .awaddr  (s_axil_awaddr),
    .wvalid  (s_axil_wvalid),
    .wready  (s_axil_wready),
    .wdata   (s_axil_wdata),
    .wstrb   (s_axil_wstrb),
    .bvalid  (s_axil_bvalid),
    .bready  (s_axil_bready),
    .bresp   (s_axil_bresp),
    .arvalid (s_axil_arvalid),
    .arready (s_axil_arready),
    .araddr  (s_axil_araddr),
    .rvalid  (s_axil_rvalid),
    .rready  (s_axil_rready),
    .rdata   (s_axil_rdata),
    .rresp   (s_axil_rresp),
    .mem     (host_if.requester)
  );

  ////////////////////////////////////////
  // shared memory
  ////////////////////////////////////////

  mem_arbiter i_arbiter (
    .clk   (bus),
    .rst_n (rst_n),
    .core  (core_if.arbiter),
    .host  (host_if.arbiter),
    .ram   (ram_if.to_mem)
  );

  data_ram i_ram (
    .clk (bus),
    .mem (ram_if.memory)
  );

endmodule

`default_nettype wire

//--- sim/tb_mem_subsys.sv
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_pkg::*;

  localparam int n_ops = 600;
  localparam time limit_ns = n_ops * 40 * 20 + 2000;

  logic bus, rst_n, dbg;
  word_t ex_mem_alures, ex_mem_dout_rs2, wb_res;
  reg_idx_t ex_mem_rs2, ex_mem_rd;
  logic ex_mem_regwrite, ex_mem_memread, ex_mem_memwrite;
  load_ctrl_e ex_mem_loadctrl;
  store_ctrl_e ex_mem_storectrl;
  word_t mem_wb_alures, mem_wb_memres;
  reg_idx_t mem_wb_rd;
  logic mem_wb_regwrite, mem_wb_memread;
  logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
  logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
  logic s_axil_rvalid, s_axil_rready;
  logic [1:0] s_axil_bresp, s_axil_rresp;
  word_t s_axil_awaddr, s_axil_wdata, s_axil_araddr, s_axil_rdata;
  be_t s_axil_wstrb;

  // reference state
  mem_word_u ref_mem [`DMEM_WORDS];
  reg_idx_t prev_rd;
  logic prev_rw;
  // expected mem/wb fields for the checker
  logic exp_valid;
  word_t exp_alures, exp_memres;
  reg_idx_t exp_rd;
  logic exp_rw, exp_mr;

  mem_subsys_top i_dut (.*);

  always #10 bus = ~bus;

  ////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////

  // addressed byte or half, wrapping at the word end
  function automatic word_t load_ref(input word_t w, input logic [1:0] off,
                                     input load_ctrl_e lc);
    logic [63:0] dbl;
    mem_word_u u;
    dbl = {w, w} >> (8 * off);
    u = dbl[31:0];
    case (lc)
      ld_lb:   return {{24{u.b[0][7]}}, u.b[0]};
      ld_lh:   return {{16{u.h[0][15]}}, u.h[0]};
      ld_lw:   return word_t'(u);
      ld_lbu:  return {24'd0, u.b[0]};
      ld_lhu:  return {16'd0, u.h[0]};
      default: return '0;
    endcase
  endfunction

  task automatic fail_now(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) fail_now($sformatf("%s got %h exp %h", what, got, exp));
  endtask

  task automatic check_rd(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) fail_now($sformatf("%s got %0d exp %0d", what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("%s got %b exp %b", what, got, exp));
  endtask

  // mem/wb compare one cycle after each issued instruction
  always @(posedge bus) begin
    #1;
    if (exp_valid) begin
      exp_valid = 1'b0;
      check_word("mem_wb_alures", mem_wb_alures, exp_alures);
      check_rd("mem_wb_rd", mem_wb_rd, exp_rd);
      check_flag("mem_wb_regwrite", mem_wb_regwrite, exp_rw);
      check_flag("mem_wb_memread", mem_wb_memread, exp_mr);
      check_word("mem_wb_memres", mem_wb_memres, exp_memres);
    end
  end

  initial begin
    #(limit_ns * 1ns);
    $display("simulation hung, watchdog ran out before the tests ended");
    $display("Test failed");
    $fatal(1);
  end

  ////////////////////////////////////////
  // pipeline driver
  ////////////////////////////////////////

  // one ex/mem instruction, called 2 ns after a rising edge
  task automatic issue(input int k, input logic [1:0] off, input word_t rs2v,
                       input reg_idx_t rs2, input reg_idx_t rd, input logic rw,
                       input logic mr, input logic mw, input load_ctrl_e lc,
                       input store_ctrl_e sc, input word_t wbv);
    word_t src;
    mem_word_u s;
    int nb;
    // high bits above the ram address are random
    ex_mem_alures = {20'($urandom), 10'(k), off};
    ex_mem_dout_rs2 = rs2v;
    ex_mem_rs2 = rs2;
    ex_mem_rd = rd;
    ex_mem_regwrite = rw;
    ex_mem_memread = mr;
    ex_mem_memwrite = mw;
    ex_mem_loadctrl = lc;
    ex_mem_storectrl = sc;
    wb_res = wbv;
    exp_alures = ex_mem_alures;
    exp_rd = rd;
    exp_rw = rw;
    exp_mr = mr;
    exp_memres = (mr && !mw) ? load_ref(ref_mem[k], off, lc) : '0;
    if (mw) begin
      // forwarded value when the previous instruction writes rs2
      src = (prev_rw && prev_rd != 0 && prev_rd == rs2) ? wbv : rs2v;
      s = src;
      nb = (sc == st_sb) ? 1 : (sc == st_sh) ? 2 : 4;
      for (int i = 0; i < nb; i++) ref_mem[k].b[(off + i) % 4] = s.b[i];
    end
    prev_rd = rd;
    prev_rw = rw;
    exp_valid = 1'b1;
    @(posedge bus);
    #2;
  endtask

  task automatic nop();
    issue(0, 2'd0, '0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, ld_none, st_none, '0);
  endtask

  task automatic load(input int k, input logic [1:0] off, input load_ctrl_e lc);
    issue(k, off, $urandom, 5'($urandom), 5'($urandom), 1'b1, 1'b1, 1'b0, lc, st_none,
          $urandom);
  endtask

  ////////////////////////////////////////
  // axi4-lite host driver
  ////////////////////////////////////////

  task automatic host_write(input int k, input word_t data, input be_t strb);
    logic hs;
    int d;
    int n;
    d = $urandom_range(3, 0);
    n = 0;
    s_axil_awaddr = {20'(k), 2'b00};
    s_axil_wdata = data;
    s_axil_wstrb = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      #8;
      hs = s_axil_awready && s_axil_wready;
      @(posedge bus);
      #2;
    end
    s_axil_awvalid = 1'b0;
    s_axil_wvalid = 1'b0;
    hs = 1'b0;
    // response held until bready, which comes late at random
    while (!hs) begin
      s_axil_bready = (n >= d);
      #8;
      hs = s_axil_bvalid && s_axil_bready;
      if (s_axil_bvalid) n++;
      if (hs) check_flag("bresp okay", s_axil_bresp == 2'b00, 1'b1);
      @(posedge bus);
      #2;
    end
    s_axil_bready = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) ref_mem[k].b[i] = data[i*8 +: 8];
    end
  endtask

  task automatic host_read(input int k);
    logic hs;
    int d;
    int n;
    word_t got;
    d = $urandom_range(3, 0);
    n = 0;
    s_axil_araddr = {20'(k), 2'b00};
    s_axil_arvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      #8;
      hs = s_axil_arready;
      @(posedge bus);
      #2;
    end
    s_axil_arvalid = 1'b0;
    hs = 1'b0;
    while (!hs) begin
      s_axil_rready = (n >= d);
      #8;
      hs = s_axil_rvalid && s_axil_rready;
      if (s_axil_rvalid) n++;
      if (hs) check_flag("rresp okay", s_axil_rresp == 2'b00, 1'b1);
      got = s_axil_rdata;
      @(posedge bus);
      #2;
    end
    s_axil_rready = 1'b0;
    check_word("host rdata", got, word_t'(ref_mem[k]));
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    word_t hold_alures, hold_memres;
    reg_idx_t hold_rd;
    logic hold_rw;
    logic hold_mr;
    time pipe_end;
    time host_end;
    void'($urandom(32'h8f2c2203));
    bus = 1'b0;
    rst_n = 1'b0;
    dbg = 1'b0;
    exp_valid = 1'b0;
    prev_rd = '0;
    prev_rw = 1'b0;
    {ex_mem_alures, ex_mem_dout_rs2, wb_res, ex_mem_rs2, ex_mem_rd} = '0;
    {ex_mem_regwrite, ex_mem_memread, ex_mem_memwrite} = '0;
    ex_mem_loadctrl = ld_none;
    ex_mem_storectrl = st_none;
    {s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready} = '0;
    {s_axil_awaddr, s_axil_wdata, s_axil_araddr} = '0;
    s_axil_wstrb = '0;
    repeat (3) @(posedge bus);
    #2;
    rst_n = 1'b1;
    #3;
    check_flag("reset mem_wb_regwrite", mem_wb_regwrite, 1'b0);
    check_flag("reset mem_wb_memread", mem_wb_memread, 1'b0);
    check_flag("reset bvalid", s_axil_bvalid, 1'b0);
    check_flag("reset rvalid", s_axil_rvalid, 1'b0);
    @(posedge bus);
    #2;

    // fill the working words first
    for (int k = 0; k < 48; k++) begin
      issue(k, 2'd0, $urandom, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1, ld_none, st_sw, '0);
    end

    // stores at every offset, each checked by lw
    for (int r = 0; r < 4; r++) begin
      for (int o = 0; o < 4; o++) begin
        for (int t = 0; t < 3; t++) begin
          issue(o + 4 * t, 2'(o), $urandom, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1, ld_none,
                (t == 0) ? st_sb : (t == 1) ? st_sh : st_sw, $urandom);
          load(o + 4 * t, 2'd0, ld_lw);
        end
      end
    end

    // narrow loads at every offset
    for (int o = 0; o < 4; o++) begin
      load(o, 2'(o), ld_lb);
      load(o + 1, 2'(o), ld_lh);
      load(o + 2, 2'(o), ld_lbu);
      load(o + 3, 2'(o), ld_lhu);
    end

    // forwarding, then rd 0 and regwrite low
    issue(0, 2'd0, '0, 5'd0, 5'd7, 1'b1, 1'b0, 1'b0, ld_none, st_none, '0);
    issue(5, 2'd0, 32'h1111_1111, 5'd7, 5'd0, 1'b0, 1'b0, 1'b1, ld_none, st_sw, 32'hcafe_f00d);
    load(5, 2'd0, ld_lw);
    issue(0, 2'd0, '0, 5'd0, 5'd0, 1'b1, 1'b0, 1'b0, ld_none, st_none, '0);
    issue(6, 2'd0, 32'h2222_2222, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1, ld_none, st_sw, 32'hdead_0001);
    load(6, 2'd0, ld_lw);
    issue(0, 2'd0, '0, 5'd0, 5'd9, 1'b0, 1'b0, 1'b0, ld_none, st_none, '0);
    issue(7, 2'd0, 32'h3333_3333, 5'd9, 5'd0, 1'b0, 1'b0, 1'b1, ld_none, st_sw, 32'hdead_0002);
    load(7, 2'd0, ld_lw);
    // last load result stays in mem/wb across the halt
    load(9, 2'd2, ld_lh);

    // halted core, host patches memory
    hold_alures = mem_wb_alures;
    hold_rd = mem_wb_rd;
    hold_rw = mem_wb_regwrite;
    hold_mr = mem_wb_memread;
    hold_memres = mem_wb_memres;
    dbg = 1'b1;
    // stage inputs that differ from the held fields
    ex_mem_alures = 32'h0000_0004;
    ex_mem_dout_rs2 = 32'hbad0_bad0;
    ex_mem_rd = ~hold_rd;
    ex_mem_regwrite = ~hold_rw;
    ex_mem_memread = 1'b0;
    ex_mem_memwrite = 1'b1;
    ex_mem_storectrl = st_sw;
    for (int i = 0; i < 8; i++) begin
      host_write(i % 4, $urandom, be_t'($urandom));
      host_read($urandom_range(3, 0));
      check_word("held alures", mem_wb_alures, hold_alures);
      check_rd("held rd", mem_wb_rd, hold_rd);
      check_flag("held regwrite", mem_wb_regwrite, hold_rw);
      check_flag("held memread", mem_wb_memread, hold_mr);
      check_word("held memres", mem_wb_memres, hold_memres);
    end
    ex_mem_memwrite = 1'b0;
    ex_mem_regwrite = 1'b0;
    @(posedge bus);
    #2;
    dbg = 1'b0;
    for (int k = 0; k < 4; k++) load(k, 2'd0, ld_lw);

    // host access blocked by back-to-back loads
    for (int r = 0; r < 2; r++) begin
      fork
        begin
          for (int i = 0; i < 20; i++) load(i % 16, 2'(i), ld_lw);
          pipe_end = $time;
          nop();
        end
        begin
          if (r == 0) host_write(40, 32'h5a5a_a5a5, 4'hf);
          else host_read(40);
          host_end = $time;
        end
      join
      check_flag("host finished after pipeline", host_end > pipe_end, 1'b1);
    end
    nop();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
